/* include/l2_cache_consts.svh */
`ifndef L2_CACHE_CONSTS_SVH
`define L2_CACHE_CONSTS_SVH

// Geometry of the L2 tag array
`define L2_SET_INDEX_WIDTH 6
`define L2_NUM_SETS 64
`define L2_TAG_WIDTH 20

// The line address is the tag above the set index
`define L2_ADDR_WIDTH (`L2_TAG_WIDTH + `L2_SET_INDEX_WIDTH)

`define L2_NUM_WAYS 4
`define L2_WAY_WIDTH 2

// One cache line and its byte enables
`define L2_LINE_BITS 512
`define L2_MASK_BITS 64

// Request op codes as they come from the arbiter
`define L2REQ_LOAD 3'd0
`define L2REQ_STORE 3'd1
`define L2REQ_FLUSH 3'd2
`define L2REQ_INVALIDATE 3'd3

`endif

/* rtl/l2_cache_pkg.sv */
`include "l2_cache_consts.svh"

package l2_pkg;

	// One entry of a tag RAM way
	typedef logic [`L2_TAG_WIDTH-1:0] l2_tag_t;

	// Pseudo-LRU tree of one set
	// Bit 0 picks the way pair, bit 1 picks inside {0,1}, bit 2 picks inside {2,3}
	typedef logic [`L2_NUM_WAYS-2:0] l2_lru_t;

	// Index of a way within a set
	typedef logic [`L2_WAY_WIDTH-1:0] l2_way_t;

	// Request operation, encoded as the arbiter sends it
	typedef enum logic [2:0]
	{
		L2_OP_LOAD = `L2REQ_LOAD,
		L2_OP_STORE = `L2REQ_STORE,
		L2_OP_FLUSH = `L2REQ_FLUSH,
		L2_OP_INVALIDATE = `L2REQ_INVALIDATE
	} l2_op_t;

endpackage

/* rtl/sram_1r1w.sv */
`timescale 1ns/1ps

// Simple dual port RAM, one read port and one write port on the same clock
module sram_1r1w #(
	parameter type data_t = logic [31:0],
	parameter int DEPTH = 64,
	parameter int ADDR_WIDTH = 6
)
(
	input logic clk,
	input logic [ADDR_WIDTH-1:0] rd_addr,
	output data_t rd_data,
	input logic [ADDR_WIDTH-1:0] wr_addr,
	input data_t wr_data,
	input logic wr_enable
);

	data_t mem [DEPTH];

	always_ff @(posedge clk)
	begin
		if (wr_enable)
			mem[wr_addr] <= wr_data;
	end

	// Read is registered; a collision with the write returns the new value
	always_ff @(posedge clk)
	begin
		if (wr_enable && wr_addr == rd_addr)
			rd_data <= wr_data;
		else
			rd_data <= mem[rd_addr];
	end

endmodule

/* rtl/cache_lru.sv */
`timescale 1ns/1ps
`include "l2_cache_consts.svh"

// Tree pseudo-LRU for a four way set associative cache
// The set presented on rd_set is looked up on the clock edge, and lru_way
// is valid in the following cycle, alongside the tag RAM outputs
module cache_lru (
	input logic clk,
	input logic rst_n,
	input logic stall_pipeline,
	input logic [`L2_SET_INDEX_WIDTH-1:0] rd_set,
	output l2_pkg::l2_way_t lru_way,
	input logic update,
	input logic [`L2_SET_INDEX_WIDTH-1:0] update_set,
	input l2_pkg::l2_way_t update_way
);

	import l2_pkg::*;

	logic [`L2_SET_INDEX_WIDTH-1:0] held_set;
	logic [`L2_SET_INDEX_WIDTH-1:0] ram_rd_set;
	logic [`L2_NUM_SETS-1:0] set_written;
	logic state_written;
	logic write_state;
	l2_lru_t ram_state;
	l2_lru_t cur_state;
	l2_lru_t next_state;

	// Follow the tree bits down to the least recently used way
	function automatic l2_way_t tree_victim(input l2_lru_t bits);
		if (bits[0])
			return {1'b1, bits[2]};
		else
			return {1'b0, bits[1]};
	endfunction

	// Point every node on the path to a way away from it
	function automatic l2_lru_t tree_touch(input l2_lru_t bits, input l2_way_t way);
		l2_lru_t result;

		result = bits;
		result[0] = ~way[1];
		if (way[1])
			result[2] = ~way[0];
		else
			result[1] = ~way[0];
		return result;
	endfunction

	// During a stall the RAM keeps reading the set already in flight,
	// which holds its output because no write can happen meanwhile
	assign ram_rd_set = stall_pipeline ? held_set : rd_set;
	assign write_state = update && !stall_pipeline;

	// Sets never touched since reset have no RAM contents yet and read as zero
	assign cur_state = state_written ? ram_state : '0;
	assign lru_way = tree_victim(cur_state);

	// The update always targets the set whose state is on the read side now
	assign next_state = tree_touch(cur_state, update_way);

	sram_1r1w #(
		.data_t(l2_lru_t),
		.DEPTH(`L2_NUM_SETS),
		.ADDR_WIDTH(`L2_SET_INDEX_WIDTH)
	) lru_ram (
		.clk(clk),
		.rd_addr(ram_rd_set),
		.rd_data(ram_state),
		.wr_addr(update_set),
		.wr_data(next_state),
		.wr_enable(write_state)
	);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			set_written <= '0;
			state_written <= 1'b0;
			held_set <= '0;
		end
		else
		begin
			if (write_state)
				set_written[update_set] <= 1'b1;

			// Forward the flag of an update landing on the set being read,
			// the RAM itself forwards the tree bits
			state_written <= set_written[ram_rd_set]
				|| (write_state && update_set == ram_rd_set);

			if (!stall_pipeline)
				held_set <= rd_set;
		end
	end

endmodule

/* rtl/l2_cache_tag.sv */
`timescale 1ns/1ps
`include "l2_cache_consts.svh"

// Tag lookup stage of the L2 cache
// Reads all four tag ways and the LRU state of the requested set, installs
// the tag of a restarted request's fetched line, and registers the request
module l2_cache_tag (
	input logic clk,
	input logic rst_n,
	input logic stall_pipeline,
	input logic arb_l2req_valid,
	input logic [1:0] arb_l2req_unit,
	input logic [1:0] arb_l2req_strand,
	input l2_pkg::l2_op_t arb_l2req_op,
	input logic [1:0] arb_l2req_way,
	input logic [`L2_ADDR_WIDTH-1:0] arb_l2req_address,
	input logic [`L2_LINE_BITS-1:0] arb_l2req_data,
	input logic [`L2_MASK_BITS-1:0] arb_l2req_mask,
	input logic arb_has_sm_data,
	input logic [`L2_LINE_BITS-1:0] arb_sm_data,
	input l2_pkg::l2_way_t arb_sm_fill_way,
	input logic hit,
	input l2_pkg::l2_way_t hit_way,
	output logic tag_l2req_valid,
	output logic [1:0] tag_l2req_unit,
	output logic [1:0] tag_l2req_strand,
	output l2_pkg::l2_op_t tag_l2req_op,
	output logic [1:0] tag_l2req_way,
	output logic [`L2_ADDR_WIDTH-1:0] tag_l2req_address,
	output logic [`L2_LINE_BITS-1:0] tag_l2req_data,
	output logic [`L2_MASK_BITS-1:0] tag_l2req_mask,
	output logic tag_has_sm_data,
	output logic [`L2_LINE_BITS-1:0] tag_sm_data,
	output l2_pkg::l2_way_t tag_sm_fill_way,
	output l2_pkg::l2_way_t tag_replace_way,
	output l2_pkg::l2_tag_t [`L2_NUM_WAYS-1:0] tag_tags,
	output logic [`L2_NUM_WAYS-1:0] tag_valids
);

	import l2_pkg::*;

	logic [`L2_SET_INDEX_WIDTH-1:0] arb_set;
	logic [`L2_SET_INDEX_WIDTH-1:0] tag_set;
	logic [`L2_SET_INDEX_WIDTH-1:0] read_set;
	l2_tag_t arb_tag;
	logic fill_enable;
	logic [`L2_NUM_WAYS-1:0] fill_ways;
	logic [`L2_NUM_WAYS-1:0] way_valid [`L2_NUM_SETS];
	logic lru_update;

	assign arb_set = arb_l2req_address[`L2_SET_INDEX_WIDTH-1:0];
	assign arb_tag = arb_l2req_address[`L2_TAG_WIDTH+`L2_SET_INDEX_WIDTH-1:`L2_SET_INDEX_WIDTH];
	assign tag_set = tag_l2req_address[`L2_SET_INDEX_WIDTH-1:0];

	// A stalled stage re-reads its own set so the RAM outputs hold
	assign read_set = stall_pipeline ? tag_set : arb_set;
	assign fill_enable = arb_has_sm_data && !stall_pipeline;

	for (genvar w = 0; w < `L2_NUM_WAYS; w++)
	begin : g_way
		assign fill_ways[w] = fill_enable && arb_sm_fill_way == l2_way_t'(w);

		sram_1r1w #(
			.data_t(l2_tag_t),
			.DEPTH(`L2_NUM_SETS),
			.ADDR_WIDTH(`L2_SET_INDEX_WIDTH)
		) tag_ram (
			.clk(clk),
			.rd_addr(read_set),
			.rd_data(tag_tags[w]),
			.wr_addr(arb_set),
			.wr_data(arb_tag),
			.wr_enable(fill_ways[w])
		);
	end

	// Valid bits live in flops so that reset empties the cache.
	// A fill is visible on the same edge, like the RAM's write forwarding
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int s = 0; s < `L2_NUM_SETS; s++)
				way_valid[s] <= '0;
			tag_valids <= '0;
		end
		else if (!stall_pipeline)
		begin
			way_valid[arb_set] <= way_valid[arb_set] | fill_ways;
			tag_valids <= way_valid[arb_set] | fill_ways;
		end
	end

	// A fill comes back from the match stage as a hit on its fill way
	assign lru_update = tag_l2req_valid && hit;

	cache_lru lru (
		.clk(clk),
		.rst_n(rst_n),
		.stall_pipeline(stall_pipeline),
		.rd_set(arb_set),
		.lru_way(tag_replace_way),
		.update(lru_update),
		.update_set(tag_set),
		.update_way(hit_way)
	);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			tag_l2req_valid <= 1'b0;
		else if (!stall_pipeline)
			tag_l2req_valid <= arb_l2req_valid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall_pipeline)
		begin
			tag_l2req_unit <= arb_l2req_unit;
			tag_l2req_strand <= arb_l2req_strand;
			tag_l2req_op <= arb_l2req_op;
			tag_l2req_way <= arb_l2req_way;
			tag_l2req_address <= arb_l2req_address;
			tag_l2req_data <= arb_l2req_data;
			tag_l2req_mask <= arb_l2req_mask;
			tag_has_sm_data <= arb_has_sm_data;
			tag_sm_data <= arb_sm_data;
			tag_sm_fill_way <= arb_sm_fill_way;
		end
	end

endmodule

/* rtl/l2_tag_match.sv */
`timescale 1ns/1ps
`include "l2_cache_consts.svh"

// Tag compare stage
// Hit and hit way are also driven back to the tag stage for the LRU update
module l2_tag_match (
	input logic clk,
	input logic rst_n,
	input logic stall_pipeline,
	input logic tag_l2req_valid,
	input logic [1:0] tag_l2req_unit,
	input logic [1:0] tag_l2req_strand,
	input l2_pkg::l2_op_t tag_l2req_op,
	input logic [`L2_ADDR_WIDTH-1:0] tag_l2req_address,
	input logic [`L2_LINE_BITS-1:0] tag_l2req_data,
	input logic [`L2_MASK_BITS-1:0] tag_l2req_mask,
	input logic tag_has_sm_data,
	input l2_pkg::l2_way_t tag_sm_fill_way,
	input l2_pkg::l2_way_t tag_replace_way,
	input l2_pkg::l2_tag_t [`L2_NUM_WAYS-1:0] tag_tags,
	input logic [`L2_NUM_WAYS-1:0] tag_valids,
	output logic hit,
	output l2_pkg::l2_way_t hit_way,
	output logic match_valid,
	output l2_pkg::l2_op_t match_op,
	output logic [`L2_ADDR_WIDTH-1:0] match_address,
	output logic [1:0] match_unit,
	output logic [1:0] match_strand,
	output logic [`L2_LINE_BITS-1:0] match_data,
	output logic [`L2_MASK_BITS-1:0] match_mask,
	output logic match_has_sm_data,
	output logic match_hit,
	output l2_pkg::l2_way_t match_hit_way,
	output l2_pkg::l2_way_t match_replace_way
);

	import l2_pkg::*;

	l2_tag_t req_tag;
	logic [`L2_NUM_WAYS-1:0] way_match;
	l2_way_t match_encoded;

	assign req_tag = tag_l2req_address[`L2_TAG_WIDTH+`L2_SET_INDEX_WIDTH-1:`L2_SET_INDEX_WIDTH];

	// At most one way can match, so OR-ing the indices encodes the hit
	always_comb
	begin
		match_encoded = '0;
		for (int w = 0; w < `L2_NUM_WAYS; w++)
		begin
			way_match[w] = tag_valids[w] && tag_tags[w] == req_tag;
			if (way_match[w])
				match_encoded = match_encoded | l2_way_t'(w);
		end
	end

	// The fetched line of a restarted request was just written to its fill way
	assign hit = tag_has_sm_data || (|way_match);
	assign hit_way = tag_has_sm_data ? tag_sm_fill_way : match_encoded;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			match_valid <= 1'b0;
		else if (!stall_pipeline)
			match_valid <= tag_l2req_valid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall_pipeline)
		begin
			match_op <= tag_l2req_op;
			match_address <= tag_l2req_address;
			match_unit <= tag_l2req_unit;
			match_strand <= tag_l2req_strand;
			match_data <= tag_l2req_data;
			match_mask <= tag_l2req_mask;
			match_has_sm_data <= tag_has_sm_data;
			match_hit <= hit;
			match_hit_way <= hit_way;
			match_replace_way <= tag_replace_way;
		end
	end

endmodule

/* rtl/l2_tag_pipeline.sv */
`timescale 1ns/1ps
`include "l2_cache_consts.svh"

// Two stage tag lookup front end of the L2 cache
module l2_tag_pipeline (
	input logic clk,
	input logic rst_n,
	input logic stall_pipeline,
	input logic arb_l2req_valid,
	input logic [1:0] arb_l2req_unit,
	input logic [1:0] arb_l2req_strand,
	input l2_pkg::l2_op_t arb_l2req_op,
	input logic [1:0] arb_l2req_way,
	input logic [`L2_ADDR_WIDTH-1:0] arb_l2req_address,
	input logic [`L2_LINE_BITS-1:0] arb_l2req_data,
	input logic [`L2_MASK_BITS-1:0] arb_l2req_mask,
	input logic arb_has_sm_data,
	input logic [`L2_LINE_BITS-1:0] arb_sm_data,
	input l2_pkg::l2_way_t arb_sm_fill_way,
	output logic match_valid,
	output l2_pkg::l2_op_t match_op,
	output logic [`L2_ADDR_WIDTH-1:0] match_address,
	output logic [1:0] match_unit,
	output logic [1:0] match_strand,
	output logic [`L2_LINE_BITS-1:0] match_data,
	output logic [`L2_MASK_BITS-1:0] match_mask,
	output logic match_has_sm_data,
	output logic match_hit,
	output l2_pkg::l2_way_t match_hit_way,
	output l2_pkg::l2_way_t match_replace_way
);

	import l2_pkg::*;

	logic tag_l2req_valid;
	logic [1:0] tag_l2req_unit;
	logic [1:0] tag_l2req_strand;
	l2_op_t tag_l2req_op;
	logic [`L2_ADDR_WIDTH-1:0] tag_l2req_address;
	logic [`L2_LINE_BITS-1:0] tag_l2req_data;
	logic [`L2_MASK_BITS-1:0] tag_l2req_mask;
	logic tag_has_sm_data;
	l2_way_t tag_sm_fill_way;
	l2_way_t tag_replace_way;
	l2_tag_t [`L2_NUM_WAYS-1:0] tag_tags;
	logic [`L2_NUM_WAYS-1:0] tag_valids;
	logic hit;
	l2_way_t hit_way;

	// The requester's way and the fetched line continue to the data stage,
	// which is not part of this block
	l2_cache_tag tag_stage (
		.clk(clk),
		.rst_n(rst_n),
		.stall_pipeline(stall_pipeline),
		.arb_l2req_valid(arb_l2req_valid),
		.arb_l2req_unit(arb_l2req_unit),
		.arb_l2req_strand(arb_l2req_strand),
		.arb_l2req_op(arb_l2req_op),
		.arb_l2req_way(arb_l2req_way),
		.arb_l2req_address(arb_l2req_address),
		.arb_l2req_data(arb_l2req_data),
		.arb_l2req_mask(arb_l2req_mask),
		.arb_has_sm_data(arb_has_sm_data),
		.arb_sm_data(arb_sm_data),
		.arb_sm_fill_way(arb_sm_fill_way),
		.hit(hit),
		.hit_way(hit_way),
		.tag_l2req_valid(tag_l2req_valid),
		.tag_l2req_unit(tag_l2req_unit),
		.tag_l2req_strand(tag_l2req_strand),
		.tag_l2req_op(tag_l2req_op),
		.tag_l2req_way(),
		.tag_l2req_address(tag_l2req_address),
		.tag_l2req_data(tag_l2req_data),
		.tag_l2req_mask(tag_l2req_mask),
		.tag_has_sm_data(tag_has_sm_data),
		.tag_sm_data(),
		.tag_sm_fill_way(tag_sm_fill_way),
		.tag_replace_way(tag_replace_way),
		.tag_tags(tag_tags),
		.tag_valids(tag_valids)
	);

	l2_tag_match match_stage (
		.clk(clk),
		.rst_n(rst_n),
		.stall_pipeline(stall_pipeline),
		.tag_l2req_valid(tag_l2req_valid),
		.tag_l2req_unit(tag_l2req_unit),
		.tag_l2req_strand(tag_l2req_strand),
		.tag_l2req_op(tag_l2req_op),
		.tag_l2req_address(tag_l2req_address),
		.tag_l2req_data(tag_l2req_data),
		.tag_l2req_mask(tag_l2req_mask),
		.tag_has_sm_data(tag_has_sm_data),
		.tag_sm_fill_way(tag_sm_fill_way),
		.tag_replace_way(tag_replace_way),
		.tag_tags(tag_tags),
		.tag_valids(tag_valids),
		.hit(hit),
		.hit_way(hit_way),
		.match_valid(match_valid),
		.match_op(match_op),
		.match_address(match_address),
		.match_unit(match_unit),
		.match_strand(match_strand),
		.match_data(match_data),
		.match_mask(match_mask),
		.match_has_sm_data(match_has_sm_data),
		.match_hit(match_hit),
		.match_hit_way(match_hit_way),
		.match_replace_way(match_replace_way)
	);

endmodule

/* testbench/l2_tag_checker.sv */
`timescale 1ns/1ps
`include "l2_cache_consts.svh"

// Consistency checks on the tag lookup stage
module l2_tag_checker (
	input logic clk,
	input logic rst_n,
	input logic arb_has_sm_data,
	input l2_pkg::l2_op_t arb_l2req_op,
	input logic tag_l2req_valid,
	input logic [`L2_ADDR_WIDTH-1:0] tag_l2req_address,
	input l2_pkg::l2_tag_t [`L2_NUM_WAYS-1:0] tag_tags,
	input logic [`L2_NUM_WAYS-1:0] tag_valids
);

	import l2_pkg::*;

	int failure_count = 0;
	l2_tag_t req_tag;
	logic [`L2_NUM_WAYS-1:0] way_hits;

	assign req_tag = tag_l2req_address[`L2_TAG_WIDTH+`L2_SET_INDEX_WIDTH-1:`L2_SET_INDEX_WIDTH];

	always_comb
	begin
		for (int w = 0; w < `L2_NUM_WAYS; w++)
			way_hits[w] = tag_valids[w] && tag_tags[w] == req_tag;
	end

	// Flush and invalidate never restart with a fetched line
	fill_op_legal: assert property (@(posedge clk) disable iff (!rst_n)
		arb_has_sm_data |-> !(arb_l2req_op inside {L2_OP_FLUSH, L2_OP_INVALIDATE}))
	else
	begin
		failure_count++;
		$error("Fill request carries a flush or invalidate op");
	end

	// A tag is installed in only one way of a set
	single_way_hit: assert property (@(posedge clk) disable iff (!rst_n)
		tag_l2req_valid |-> $onehot0(way_hits))
	else
	begin
		failure_count++;
		$error("More than one valid way matches the request tag");
	end

	// Reset empties the stage register and the valid bits it presents
	empty_after_reset: assert property (@(posedge clk)
		!rst_n |=> !tag_l2req_valid && tag_valids == '0)
	else
	begin
		failure_count++;
		$error("Tag stage is not empty in the cycle after reset");
	end

endmodule

bind l2_cache_tag l2_tag_checker tag_checks (
	.clk(clk),
	.rst_n(rst_n),
	.arb_has_sm_data(arb_has_sm_data),
	.arb_l2req_op(arb_l2req_op),
	.tag_l2req_valid(tag_l2req_valid),
	.tag_l2req_address(tag_l2req_address),
	.tag_tags(tag_tags),
	.tag_valids(tag_valids)
);

/* testbench/tb_l2_tag_pipeline.sv */
`timescale 1ns/1ps
`include "l2_cache_consts.svh"

module tb_l2_tag_pipeline;

	import l2_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 10;
	// Requests, idle and stall cycles of all tests together, with room to spare
	localparam int MAX_TEST_CYCLES = 80;
	localparam int MARGIN_CYCLES = 50;
	localparam int TIMEOUT_NS = (RESET_CYCLES + MAX_TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

	typedef struct {
		int due;
		logic valid;
		logic hit;
		l2_way_t hit_way;
		l2_way_t replace_way;
		l2_op_t op;
		logic [`L2_ADDR_WIDTH-1:0] address;
		logic [1:0] unit;
		logic [1:0] strand;
		logic [`L2_LINE_BITS-1:0] data;
		logic [`L2_MASK_BITS-1:0] mask;
		logic has_sm;
	} result_t;

	logic clk;
	logic rst_n;
	logic stall_pipeline;
	logic arb_l2req_valid;
	logic [1:0] arb_l2req_unit;
	logic [1:0] arb_l2req_strand;
	l2_op_t arb_l2req_op;
	logic [1:0] arb_l2req_way;
	logic [`L2_ADDR_WIDTH-1:0] arb_l2req_address;
	logic [`L2_LINE_BITS-1:0] arb_l2req_data;
	logic [`L2_MASK_BITS-1:0] arb_l2req_mask;
	logic arb_has_sm_data;
	logic [`L2_LINE_BITS-1:0] arb_sm_data;
	l2_way_t arb_sm_fill_way;
	logic match_valid;
	l2_op_t match_op;
	logic [`L2_ADDR_WIDTH-1:0] match_address;
	logic [1:0] match_unit;
	logic [1:0] match_strand;
	logic [`L2_LINE_BITS-1:0] match_data;
	logic [`L2_MASK_BITS-1:0] match_mask;
	logic match_has_sm_data;
	logic match_hit;
	l2_way_t match_hit_way;
	l2_way_t match_replace_way;

	// Reference model of the tag array and its replacement state
	l2_tag_t model_tag [`L2_NUM_SETS][`L2_NUM_WAYS];
	logic [`L2_NUM_WAYS-1:0] model_valid [`L2_NUM_SETS];
	l2_lru_t model_lru [`L2_NUM_SETS];
	logic set_used [`L2_NUM_SETS];

	result_t pending [$];
	result_t last_seen;
	int edge_count = 0;

	l2_tag_pipeline DUT (.*);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("Watchdog expired: the tests did not finish in time");
		$display("sim failed");
		$fatal(1, "Timeout");
	end

	task automatic check_value(input string what, input logic [`L2_LINE_BITS-1:0] actual,
		input logic [`L2_LINE_BITS-1:0] expected);
		if (actual !== expected)
		begin
			$display("Error at time %0t: %s is %0h, expected %0h", $time, what, actual, expected);
			$display("sim failed");
			$fatal(1, "Mismatch");
		end
	endtask

	// Bit 0 picks the pair, bits 1 and 2 the way inside it, a set bit means the upper one
	function automatic l2_way_t lru_victim(input l2_lru_t bits);
		if (!bits[0])
			return bits[1] ? 2'd1 : 2'd0;
		else
			return bits[2] ? 2'd3 : 2'd2;
	endfunction

	function automatic l2_lru_t lru_touch(input l2_lru_t bits, input l2_way_t way);
		l2_lru_t next;

		next = bits;
		next[0] = way < 2;
		if (way < 2)
			next[1] = way == 0;
		else
			next[2] = way == 2;
		return next;
	endfunction

	function automatic result_t sample_outputs();
		result_t r;

		r.due = 0;
		r.valid = match_valid;
		r.hit = match_hit;
		r.hit_way = match_hit_way;
		r.replace_way = match_replace_way;
		r.op = match_op;
		r.address = match_address;
		r.unit = match_unit;
		r.strand = match_strand;
		r.data = match_data;
		r.mask = match_mask;
		r.has_sm = match_has_sm_data;
		return r;
	endfunction

	task automatic compare_results(input string where, input result_t actual,
		input result_t expected, input logic with_hit_way);
		check_value({where, " match_valid"}, actual.valid, expected.valid);
		check_value({where, " match_hit"}, actual.hit, expected.hit);
		if (with_hit_way)
			check_value({where, " match_hit_way"}, actual.hit_way, expected.hit_way);
		check_value({where, " match_replace_way"}, actual.replace_way, expected.replace_way);
		check_value({where, " match_op"}, actual.op, expected.op);
		check_value({where, " match_address"}, actual.address, expected.address);
		check_value({where, " match_unit"}, actual.unit, expected.unit);
		check_value({where, " match_strand"}, actual.strand, expected.strand);
		check_value({where, " match_data"}, actual.data, expected.data);
		check_value({where, " match_mask"}, actual.mask, expected.mask);
		check_value({where, " match_has_sm_data"}, actual.has_sm, expected.has_sm);
	endtask

	// One clock edge, then the outputs are checked 1 ns later, before new inputs go on
	task automatic tick();
		logic stalled;
		result_t now;
		result_t expected;

		@(posedge clk);
		stalled = stall_pipeline;
		#1;
		now = sample_outputs();
		if (!stalled)
			edge_count++;
		if (stalled)
			compare_results("stalled", now, last_seen, 1'b1);
		else if (pending.size() > 0 && pending[0].due == edge_count)
		begin
			expected = pending.pop_front();
			compare_results("result", now, expected, expected.hit);
		end
		else
			check_value("idle match_valid", match_valid, 1'b0);
		check_value("checker assertion failures", DUT.tag_stage.tag_checks.failure_count, 0);
		last_seen = now;
	endtask

	task automatic drive_request(input l2_op_t op, input logic [`L2_ADDR_WIDTH-1:0] address,
		input logic fill, input l2_way_t fill_way);
		logic [`L2_LINE_BITS-1:0] line;
		logic [`L2_LINE_BITS-1:0] fetched;

		for (int i = 0; i < `L2_LINE_BITS / 32; i++)
		begin
			line = {line[`L2_LINE_BITS-33:0], $urandom()};
			fetched = {fetched[`L2_LINE_BITS-33:0], $urandom()};
		end
		arb_l2req_valid = 1'b1;
		arb_l2req_unit = 2'($urandom());
		arb_l2req_strand = 2'($urandom());
		arb_l2req_way = 2'($urandom());
		arb_l2req_op = op;
		arb_l2req_address = address;
		arb_l2req_data = line;
		arb_l2req_mask = {$urandom(), $urandom()};
		arb_has_sm_data = fill;
		arb_sm_data = fetched;
		arb_sm_fill_way = fill_way;
	endtask

	// Applies the request on the arb inputs to the model and queues its result
	task automatic predict();
		result_t r;
		logic [`L2_SET_INDEX_WIDTH-1:0] set;
		l2_tag_t tag;

		set = arb_l2req_address[`L2_SET_INDEX_WIDTH-1:0];
		tag = arb_l2req_address[`L2_ADDR_WIDTH-1:`L2_SET_INDEX_WIDTH];
		r.due = edge_count + 2;
		r.valid = 1'b1;
		r.hit = 1'b0;
		r.hit_way = '0;
		if (arb_has_sm_data)
		begin
			model_tag[set][arb_sm_fill_way] = tag;
			model_valid[set][arb_sm_fill_way] = 1'b1;
			r.hit = 1'b1;
			r.hit_way = arb_sm_fill_way;
		end
		else
		begin
			for (int w = 0; w < `L2_NUM_WAYS; w++)
			begin
				if (model_valid[set][w] && model_tag[set][w] == tag)
				begin
					r.hit = 1'b1;
					r.hit_way = l2_way_t'(w);
				end
			end
		end
		r.replace_way = lru_victim(model_lru[set]);
		if (r.hit)
			model_lru[set] = lru_touch(model_lru[set], r.hit_way);
		r.op = arb_l2req_op;
		r.address = arb_l2req_address;
		r.unit = arb_l2req_unit;
		r.strand = arb_l2req_strand;
		r.data = arb_l2req_data;
		r.mask = arb_l2req_mask;
		r.has_sm = arb_has_sm_data;
		pending.push_back(r);
	endtask

	task automatic issue(input l2_op_t op, input logic [`L2_ADDR_WIDTH-1:0] address,
		input logic fill, input l2_way_t fill_way);
		drive_request(op, address, fill, fill_way);
		stall_pipeline = 1'b0;
		predict();
		tick();
	endtask

	task automatic idle(input int cycles);
		arb_l2req_valid = 1'b0;
		arb_has_sm_data = 1'b0;
		stall_pipeline = 1'b0;
		repeat (cycles)
			tick();
	endtask

	task automatic pick_set(output logic [`L2_SET_INDEX_WIDTH-1:0] set);
		do
		begin
			set = `L2_SET_INDEX_WIDTH'($urandom());
		end
		while (set_used[set]);
		set_used[set] = 1'b1;
	endtask

	// A tag that no valid way of the set holds yet
	task automatic new_address(input logic [`L2_SET_INDEX_WIDTH-1:0] set,
		output logic [`L2_ADDR_WIDTH-1:0] address);
		l2_tag_t tag;
		logic unique_tag;

		unique_tag = 1'b0;
		while (!unique_tag)
		begin
			tag = l2_tag_t'($urandom());
			unique_tag = 1'b1;
			for (int w = 0; w < `L2_NUM_WAYS; w++)
				if (model_valid[set][w] && model_tag[set][w] == tag)
					unique_tag = 1'b0;
		end
		address = {tag, set};
	endtask

	task automatic test_reset_misses();
		logic [`L2_SET_INDEX_WIDTH-1:0] set;
		logic [`L2_ADDR_WIDTH-1:0] address;

		repeat (6)
		begin
			pick_set(set);
			new_address(set, address);
			issue(L2_OP_LOAD, address, 1'b0, '0);
		end
		idle(2);
	endtask

	task automatic test_fill_then_hit();
		logic [`L2_SET_INDEX_WIDTH-1:0] set;
		logic [`L2_ADDR_WIDTH-1:0] filled;
		logic [`L2_ADDR_WIDTH-1:0] other;

		pick_set(set);
		new_address(set, filled);
		issue(L2_OP_LOAD, filled, 1'b1, l2_way_t'($urandom()));
		idle(1);
		issue(L2_OP_LOAD, filled, 1'b0, '0);
		new_address(set, other);
		issue(L2_OP_STORE, other, 1'b0, '0);
		idle(2);
	endtask

	task automatic test_lru_order();
		logic [`L2_SET_INDEX_WIDTH-1:0] set;
		logic [`L2_ADDR_WIDTH-1:0] way_address [`L2_NUM_WAYS];
		logic [`L2_ADDR_WIDTH-1:0] address;
		l2_way_t way;

		pick_set(set);
		repeat (`L2_NUM_WAYS)
		begin
			new_address(set, address);
			way = lru_victim(model_lru[set]);
			way_address[way] = address;
			issue(L2_OP_LOAD, address, 1'b1, way);
		end
		// Hits in a scrambled order move the victim around the tree
		issue(L2_OP_LOAD, way_address[1], 1'b0, '0);
		issue(L2_OP_STORE, way_address[3], 1'b0, '0);
		issue(L2_OP_LOAD, way_address[0], 1'b0, '0);
		issue(L2_OP_LOAD, way_address[2], 1'b0, '0);
		issue(L2_OP_LOAD, way_address[1], 1'b0, '0);
		new_address(set, address);
		issue(L2_OP_LOAD, address, 1'b0, '0);
		idle(2);
	endtask

	task automatic test_stall_hold();
		logic [`L2_SET_INDEX_WIDTH-1:0] set;
		logic [`L2_ADDR_WIDTH-1:0] filled;
		logic [`L2_ADDR_WIDTH-1:0] other;

		pick_set(set);
		new_address(set, filled);
		issue(L2_OP_LOAD, filled, 1'b1, l2_way_t'($urandom()));
		issue(L2_OP_LOAD, filled, 1'b0, '0);
		arb_l2req_valid = 1'b0;
		arb_has_sm_data = 1'b0;
		stall_pipeline = 1'b1;
		repeat (4)
			tick();
		// A request waiting on the inputs during a stall is taken on release
		drive_request(L2_OP_STORE, filled, 1'b0, '0);
		repeat (3)
			tick();
		stall_pipeline = 1'b0;
		predict();
		tick();
		new_address(set, other);
		issue(L2_OP_LOAD, other, 1'b0, '0);
		idle(2);
	endtask

	task automatic test_back_to_back();
		logic [`L2_SET_INDEX_WIDTH-1:0] set;
		logic [`L2_ADDR_WIDTH-1:0] first;
		logic [`L2_ADDR_WIDTH-1:0] second;

		pick_set(set);
		new_address(set, first);
		issue(L2_OP_STORE, first, 1'b1, l2_way_t'($urandom()));
		issue(L2_OP_LOAD, first, 1'b0, '0);
		new_address(set, second);
		issue(L2_OP_LOAD, second, 1'b1, lru_victim(model_lru[set]));
		issue(L2_OP_STORE, second, 1'b0, '0);
		issue(L2_OP_FLUSH, first, 1'b0, '0);
		issue(L2_OP_INVALIDATE, second, 1'b0, '0);
		issue(L2_OP_LOAD, first, 1'b0, '0);
		idle(2);
	endtask

	initial
	begin
		void'($urandom(50));
		rst_n = 1'b0;
		stall_pipeline = 1'b0;
		arb_l2req_valid = 1'b0;
		arb_l2req_unit = '0;
		arb_l2req_strand = '0;
		arb_l2req_op = L2_OP_LOAD;
		arb_l2req_way = '0;
		arb_l2req_address = '0;
		arb_l2req_data = '0;
		arb_l2req_mask = '0;
		arb_has_sm_data = 1'b0;
		arb_sm_data = '0;
		arb_sm_fill_way = '0;
		for (int s = 0; s < `L2_NUM_SETS; s++)
		begin
			model_valid[s] = '0;
			model_lru[s] = '0;
			set_used[s] = 1'b0;
		end
		repeat (RESET_CYCLES)
			@(posedge clk);
		#1;
		rst_n = 1'b1;
		idle(1);

		test_reset_misses();
		test_fill_then_hit();
		test_lru_order();
		test_stall_hold();
		test_back_to_back();

		if (pending.size() != 0)
		begin
			$display("Error at time %0t: %0d requests never reached the outputs",
				$time, pending.size());
			$display("sim failed");
			$fatal(1, "Lost requests");
		end
		else
		begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

/* files.f */
+incdir+include
rtl/l2_cache_pkg.sv
rtl/sram_1r1w.sv
rtl/cache_lru.sv
rtl/l2_cache_tag.sv
rtl/l2_tag_match.sv
rtl/l2_tag_pipeline.sv
testbench/l2_tag_checker.sv
testbench/tb_l2_tag_pipeline.sv
